//--- hw/cache_pkg.sv
// Cache geometry package
// Sizes, width types and controller states of the single-block
// direct-mapped cache. One block of 128 words sits behind one tag.
`default_nettype none

package cache_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned DATA_W     = 32;
    localparam int unsigned LINE_WORDS = 128;
    // Byte offset inside one word
    localparam int unsigned OFFSET_W   = 2;
    // Word index inside the block
    localparam int unsigned INDEX_W    = $clog2(LINE_WORDS);
    // Address bits above bit 8 name the block
    localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // --------------------------------------------------
    // Width types
    // --------------------------------------------------
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    // Also serves as the burst beat counter
    typedef logic [INDEX_W-1:0]  word_idx_t;
    typedef logic [DATA_W/8-1:0] strb_t;

    // Controller states
    // Writeback runs through WB_*, refill through FILL_*
    typedef enum logic [2:0] {
        IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA
    } cache_state_t;

endpackage

`default_nettype wire

//--- hw/axi_burst_pkg.sv
// Burst bus package
// Request and response bundles of the reduced AXI burst bus, the CPU
// request bundle and the burst constants that stay fixed on this bus
`default_nettype none

package axi_burst_pkg;

    import cache_pkg::*;

    // --------------------------------------------------
    // Fixed burst shape
    // --------------------------------------------------
    // One burst moves the whole block
    localparam int unsigned BURST_LEN        = LINE_WORDS;
    localparam int unsigned BURST_SIZE_BYTES = DATA_W / 8;
    localparam logic [1:0]  RESP_OKAY        = 2'b00;

    // CPU side request, held stable while stall is high
    typedef struct packed {
        addr_t addr;
        word_t write_data;
        logic  read_enable;
        logic  write_enable;
        strb_t byte_enable;
    } cpu_req_t;

    // Cache to memory
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        word_t w_data;
        logic  w_last;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } bus_req_t;

    // Memory to cache
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic [1:0] b_resp;
        logic       ar_ready;
        logic       r_valid;
        word_t      r_data;
        logic       r_last;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- hw/block_store.sv
// Block data store
// Holds the 128 words of the cached block. The CPU port reads
// asynchronously and merges byte-masked hit writes. The burst port
// takes refill beats and presents the writeback word at the beat index.
`default_nettype none

module block_store
    import cache_pkg::*;
(
    input  wire logic      clk,

    // CPU word port
    input  wire word_idx_t cpu_index,
    input  wire word_t     write_data,
    input  wire strb_t     byte_enable,
    input  wire logic      hit_write,
    output word_t          read_data,

    // Burst word port
    input  wire word_idx_t burst_index,
    input  wire logic      fill_write,
    input  wire word_t     fill_data,
    output word_t          wb_data
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    word_t mem [LINE_WORDS];

    // Byte lanes widened to a bit mask
    word_t byte_mask;
    // Addressed word with the enabled bytes replaced
    word_t merged_word;

    always_comb begin
        for (int lane = 0; lane < $bits(strb_t); lane++) begin
            byte_mask[lane*8 +: 8] = {8{byte_enable[lane]}};
        end
    end

    assign merged_word = (mem[cpu_index] & ~byte_mask) | (write_data & byte_mask);

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    // Hit writes only happen in IDLE and fills only during the read burst,
    // so the two never meet in the same cycle
    always_ff @(posedge clk) begin
        if (hit_write) begin
            mem[cpu_index] <= merged_word;
        end else if (fill_write) begin
            // One refill beat per accepted r beat
            mem[burst_index] <= fill_data;
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    // Hit read data in the same cycle as the address
    assign read_data = mem[cpu_index];

    // Writeback word follows the beat counter
    // stays put while w_ready is low
    assign wb_data = mem[burst_index];

endmodule

`default_nettype wire

//--- hw/line_tag.sv
// Block tag and status
// Keeps the tag, valid and dirty bits of the single block and
// compares the stored tag against the request to produce hit
`default_nettype none

module line_tag
    import cache_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,

    input  wire tag_t req_tag,
    input  wire logic fill_done,
    input  wire logic wb_done,
    input  wire logic hit_write,

    output logic      hit,
    output logic      dirty,
    output tag_t      line_tag
);

    tag_t tag_q;
    logic valid_q;
    logic dirty_q;

    // --------------------------------------------------
    // Status bits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else if (fill_done) begin
            // Fresh block from memory is clean
            valid_q <= 1'b1;
            dirty_q <= 1'b0;
        end else if (wb_done) begin
            dirty_q <= 1'b0;
        end else if (hit_write) begin
            dirty_q <= 1'b1;
        end
    end

    // Tag follows the request that caused the refill
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q <= req_tag;
        end
    end

    assign hit      = valid_q && (tag_q == req_tag);
    assign dirty    = dirty_q;
    assign line_tag = tag_q;

endmodule

`default_nettype wire

//--- hw/refill_ctrl.sv
// Miss and flush controller
// Runs the writeback and refill bursts on the reduced AXI bus,
// counts the burst beats, drives the store's burst port and raises
// stall for misses, flushes and any non-idle state
`default_nettype none

module refill_ctrl
    import cache_pkg::*;
    import axi_burst_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire cpu_req_t  cpu,
    input  wire logic      flush,

    // Block status from the tag
    input  wire logic      hit,
    input  wire logic      dirty,
    input  wire tag_t      line_tag,
    input  wire word_t     wb_data,

    input  wire bus_rsp_t  bus_rsp,
    output bus_req_t       bus_req,

    output logic           hit_write,
    output logic           fill_write,
    output logic           fill_done,
    output logic           wb_done,
    output word_idx_t      burst_index,
    output logic           stall
);

    // Zero bits below the tag in a block base address
    localparam int unsigned BASE_ZERO_W = $clog2(BURST_LEN * BURST_SIZE_BYTES);
    localparam word_idx_t   LAST_BEAT   = word_idx_t'(BURST_LEN - 1);

    cache_state_t state_q;
    cache_state_t state_d;
    word_idx_t    beat_q;
    word_idx_t    beat_d;
    // Set when the writeback came from a flush order
    logic         flush_wb_q;
    logic         flush_wb_d;

    logic         req_active;
    logic         miss;
    logic         last_beat;
    tag_t         req_tag;
    addr_t        wb_base;
    addr_t        fill_base;

    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------
    // Writes with no byte enabled count as no request
    assign req_active = cpu.read_enable | (cpu.write_enable & (|cpu.byte_enable));
    assign miss       = req_active & ~hit;
    assign req_tag    = cpu.addr[ADDR_W-1 -: TAG_W];
    assign last_beat  = (beat_q == LAST_BEAT);

    // Bursts always start at word 0 of the block
    assign wb_base   = {line_tag, {BASE_ZERO_W{1'b0}}};
    assign fill_base = {req_tag, {BASE_ZERO_W{1'b0}}};

    // Stall in the request cycle itself, before the FSM leaves IDLE
    assign stall     = (state_q != IDLE) | miss | flush;
    assign hit_write = (state_q == IDLE) & ~flush & hit & cpu.write_enable
                     & (|cpu.byte_enable);

    assign burst_index = beat_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            beat_q     <= '0;
            flush_wb_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            beat_q     <= beat_d;
            flush_wb_q <= flush_wb_d;
        end
    end

    // --------------------------------------------------
    // FSM and bus handshakes
    // --------------------------------------------------
    always_comb begin
        state_d    = state_q;
        beat_d     = beat_q;
        flush_wb_d = flush_wb_q;
        fill_write = 1'b0;
        fill_done  = 1'b0;
        wb_done    = 1'b0;

        // Payload is driven all the time, only the valids move
        bus_req         = '0;
        bus_req.aw_addr = wb_base;
        bus_req.w_data  = wb_data;
        bus_req.w_last  = last_beat;
        bus_req.ar_addr = fill_base;

        case (state_q)
            IDLE: begin
                beat_d = '0;
                // Flush wins over a pending miss
                if (flush) begin
                    flush_wb_d = 1'b1;
                    state_d    = WB_ADDR;
                end else if (miss) begin
                    flush_wb_d = 1'b0;
                    state_d    = dirty ? WB_ADDR : FILL_ADDR;
                end
            end
            WB_ADDR: begin
                bus_req.aw_valid = 1'b1;
                if (bus_rsp.aw_ready) begin
                    state_d = WB_DATA;
                end
            end
            WB_DATA: begin
                bus_req.w_valid = 1'b1;
                // Counter wraps to 0 after beat 127, ready for the refill
                if (bus_rsp.w_ready) begin
                    beat_d = beat_q + word_idx_t'(1);
                    if (last_beat) begin
                        state_d = WB_RESP;
                    end
                end
            end
            WB_RESP: begin
                bus_req.b_ready = 1'b1;
                // Any response code ends the writeback
                if (bus_rsp.b_valid) begin
                    wb_done = 1'b1;
                    state_d = flush_wb_q ? IDLE : FILL_ADDR;
                end
            end
            FILL_ADDR: begin
                bus_req.ar_valid = 1'b1;
                if (bus_rsp.ar_ready) begin
                    state_d = FILL_DATA;
                end
            end
            FILL_DATA: begin
                bus_req.r_ready = 1'b1;
                if (bus_rsp.r_valid) begin
                    fill_write = 1'b1;
                    beat_d     = beat_q + word_idx_t'(1);
                    // r_last closes the burst and loads the tag
                    if (bus_rsp.r_last) begin
                        fill_done = 1'b1;
                        state_d   = IDLE;
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/dm_cache.sv
// Single-block direct-mapped cache, top level
// Splits the CPU address into tag and word index and connects the
// data store, the tag state and the miss controller
`default_nettype none

module dm_cache
    import cache_pkg::*;
    import axi_burst_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,

    input  wire cpu_req_t cpu,
    input  wire logic     flush,

    input  wire bus_rsp_t bus_rsp,
    output bus_req_t      bus_req,

    output word_t         read_data,
    output logic          stall
);

    // --------------------------------------------------
    // Address split
    // --------------------------------------------------
    word_idx_t cpu_index;
    tag_t      req_tag;

    assign cpu_index = cpu.addr[OFFSET_W +: INDEX_W];
    assign req_tag   = cpu.addr[ADDR_W-1 -: TAG_W];

    // Status from the tag to the controller
    logic      hit;
    logic      dirty;
    tag_t      stored_tag;

    // Burst port and update strobes
    word_t     wb_data;
    word_idx_t burst_index;
    logic      hit_write;
    logic      fill_write;
    logic      fill_done;
    logic      wb_done;

    block_store u_store (
        .clk         (clk),
        .cpu_index   (cpu_index),
        .write_data  (cpu.write_data),
        .byte_enable (cpu.byte_enable),
        .hit_write   (hit_write),
        .read_data   (read_data),
        .burst_index (burst_index),
        .fill_write  (fill_write),
        .fill_data   (bus_rsp.r_data),
        .wb_data     (wb_data)
    );

    line_tag u_tag (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_tag   (req_tag),
        .fill_done (fill_done),
        .wb_done   (wb_done),
        .hit_write (hit_write),
        .hit       (hit),
        .dirty     (dirty),
        .line_tag  (stored_tag)
    );

    refill_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu         (cpu),
        .flush       (flush),
        .hit         (hit),
        .dirty       (dirty),
        .line_tag    (stored_tag),
        .wb_data     (wb_data),
        .bus_rsp     (bus_rsp),
        .bus_req     (bus_req),
        .hit_write   (hit_write),
        .fill_write  (fill_write),
        .fill_done   (fill_done),
        .wb_done     (wb_done),
        .burst_index (burst_index),
        .stall       (stall)
    );

endmodule

`default_nettype wire

//--- tb/dm_cache_properties.sv
// Burst bus protocol checks
// Bound into the miss controller. Watches valid and ready pairs,
// the w_last position and stall against the FSM state
`default_nettype none

module dm_cache_properties
    import cache_pkg::*;
    import axi_burst_pkg::*;
(
    input wire logic         clk,
    input wire logic         rst_n,
    input wire bus_req_t     bus_req,
    input wire bus_rsp_t     bus_rsp,
    input wire cache_state_t state,
    input wire logic         stall
);
    timeunit 1ns;
    timeprecision 1ps;

    // Write beats accepted since the last address handshake
    int unsigned w_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_count <= 0;
        end else if (bus_req.aw_valid && bus_rsp.aw_ready) begin
            w_count <= 0;
        end else if (bus_req.w_valid && bus_rsp.w_ready) begin
            w_count <= w_count + 1;
        end
    end

    // --------------------------------------------------
    // Valid held with stable payload until ready
    // --------------------------------------------------
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.aw_valid && !bus_rsp.aw_ready |=>
            bus_req.aw_valid && $stable(bus_req.aw_addr))
        else $error("aw_valid dropped or aw_addr moved before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.w_valid && !bus_rsp.w_ready |=>
            bus_req.w_valid && $stable(bus_req.w_data) && $stable(bus_req.w_last))
        else $error("w_valid dropped or w payload moved before w_ready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.ar_valid && !bus_rsp.ar_ready |=>
            bus_req.ar_valid && $stable(bus_req.ar_addr))
        else $error("ar_valid dropped or ar_addr moved before ar_ready");

    // Last flag only on the final write beat
    w_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.w_valid |-> (bus_req.w_last == (w_count == BURST_LEN - 1)))
        else $error("w_last does not match beat 127");

    // Stall ends only with the last read beat or the write response
    busy_stall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(stall) |-> ($past(state) == WB_RESP) || ($past(state) == FILL_DATA))
        else $error("stall dropped while the controller is busy");

endmodule

bind refill_ctrl dm_cache_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .state   (state_q),
    .stall   (stall)
);

`default_nettype wire

//--- tb/dm_cache_tb.sv
// Testbench of the single-block direct-mapped cache
// Drives CPU accesses and flushes against a behavioral burst memory,
// checks read data, stall and bus traffic, first with a memory that is
// always ready and then with random back-pressure
`default_nettype none

module dm_cache_tb
    import cache_pkg::*;
    import axi_burst_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // About 10 bursts of 128 beats at up to 4 cycles a beat, with margin
    localparam int MAX_CYCLES = 20000;
    localparam int LAST_BEAT  = BURST_LEN - 1;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     flush;
    cpu_req_t cpu_req;
    bus_rsp_t bus_rsp;
    bus_req_t bus_req;
    word_t    read_data;
    logic     stall;

    // --------------------------------------------------
    // Memory model state
    // --------------------------------------------------
    // Sparse words keyed by word address
    word_t  mem_model [addr_t];
    integer seed = 32'h9366_7587;
    logic   bp_en = 1'b0;
    // 0 wait for address, 1 data beats, 2 response
    int     wr_phase = 0;
    int     wr_beat = 0;
    int     rd_beat = 0;
    logic   rd_active = 1'b0;
    logic   r_taken;
    // Last burst addresses, read by the tests
    addr_t  aw_addr_q = '0;
    addr_t  ar_addr_q = '0;
    int     wr_bursts = 0;
    int     rd_bursts = 0;

    string  pass_name = "";
    string  test_name = "reset";
    int     cycle_count = 0;
    // Word written in the hit test, expected again in the writeback
    word_t  merged_word;

    dm_cache u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu       (cpu_req),
        .flush     (flush),
        .bus_rsp   (bus_rsp),
        .bus_req   (bus_req),
        .read_data (read_data),
        .stall     (stall)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped at the cycle limit");
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Contents of a word nobody has written
    function automatic word_t pattern_word(input addr_t addr);
        return (addr >> 2) ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t model_word(input addr_t addr);
        if (mem_model.exists(addr >> 2)) begin
            return mem_model[addr >> 2];
        end
        return pattern_word(addr);
    endfunction

    // Old word with only the enabled bytes replaced
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strb_t be);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Ready or valid for the next cycle, 3 in 4 under back-pressure
    function automatic logic pick_ready();
        if (!bp_en) begin
            return 1'b1;
        end
        return ($random(seed) & 3) != 0;
    endfunction

    // --------------------------------------------------
    // Burst memory model
    // --------------------------------------------------
    initial begin : memory_model
        bus_rsp        = '0;
        bus_rsp.b_resp = RESP_OKAY;
        forever begin
            @(posedge clk);
            r_taken = bus_req.r_ready && bus_rsp.r_valid;
            if (!rst_n) begin
                wr_phase  = 0;
                rd_active = 1'b0;
            end else begin
                if (bus_req.aw_valid && bus_rsp.aw_ready) begin
                    check_equal("aw_addr block aligned", 32'h0, bus_req.aw_addr & 32'h1FF);
                    aw_addr_q = bus_req.aw_addr;
                    wr_beat   = 0;
                    wr_phase  = 1;
                    wr_bursts++;
                end
                if (bus_req.w_valid && bus_rsp.w_ready) begin
                    check_equal("w_last position", 32'(wr_beat == LAST_BEAT),
                                32'(bus_req.w_last));
                    mem_model[(aw_addr_q >> 2) + addr_t'(wr_beat)] = bus_req.w_data;
                    if (wr_beat == LAST_BEAT) begin
                        wr_phase = 2;
                    end
                    wr_beat++;
                end
                if (bus_req.b_ready && bus_rsp.b_valid) begin
                    wr_phase = 0;
                end
                if (bus_req.ar_valid && bus_rsp.ar_ready) begin
                    check_equal("ar_addr block aligned", 32'h0, bus_req.ar_addr & 32'h1FF);
                    ar_addr_q = bus_req.ar_addr;
                    rd_beat   = 0;
                    rd_active = 1'b1;
                    rd_bursts++;
                end
                if (r_taken) begin
                    if (bus_rsp.r_last) begin
                        rd_active = 1'b0;
                    end
                    rd_beat++;
                end
            end
            #1;
            // Readies roll each cycle
            bus_rsp.aw_ready = (wr_phase == 0) && pick_ready();
            bus_rsp.w_ready  = (wr_phase == 1) && pick_ready();
            bus_rsp.ar_ready = !rd_active && pick_ready();
            // A raised valid waits for its ready
            if (wr_phase != 2) begin
                bus_rsp.b_valid = 1'b0;
            end else if (!bus_rsp.b_valid) begin
                bus_rsp.b_valid = pick_ready();
            end
            if (!rd_active) begin
                bus_rsp.r_valid = 1'b0;
            end else if (!bus_rsp.r_valid || r_taken) begin
                bus_rsp.r_valid = pick_ready();
                bus_rsp.r_data  = model_word(ar_addr_q + addr_t'(rd_beat * 4));
                bus_rsp.r_last  = (rd_beat == LAST_BEAT);
            end
        end
    end

    // --------------------------------------------------
    // CPU side tasks
    // --------------------------------------------------
    // One access, held until stall drops, result sampled mid-cycle
    task automatic cpu_access(input addr_t addr, input logic wr, input word_t wdata,
                              input strb_t be, output word_t rdata, output int waits);
        @(posedge clk);
        #1;
        cpu_req.addr         = addr;
        cpu_req.write_data   = wdata;
        cpu_req.read_enable  = !wr;
        cpu_req.write_enable = wr;
        cpu_req.byte_enable  = be;
        waits = 0;
        @(negedge clk);
        while (stall) begin
            waits++;
            @(negedge clk);
        end
        rdata = read_data;
        @(posedge clk);
        #1;
        cpu_req.read_enable  = 1'b0;
        cpu_req.write_enable = 1'b0;
    endtask

    // One-cycle flush order, then wait for the writeback to end
    task automatic flush_line();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_traffic(input int wr_exp, input int rd_exp);
        check_equal("write bursts", wr_exp, wr_bursts);
        check_equal("read bursts", rd_exp, rd_bursts);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_after_reset();
        test_name = "after reset";
        @(negedge clk);
        check_equal("bus valids and readies", 32'h0, 32'({bus_req.aw_valid,
                    bus_req.w_valid, bus_req.b_ready, bus_req.ar_valid, bus_req.r_ready}));
        check_equal("stall", 32'h0, 32'(stall));
    endtask

    // Miss on a clean line refills only, then a hit in the same block
    task automatic test_read_miss(input addr_t base);
        word_t data;
        int    waits;
        int    wr0;
        int    rd0;
        test_name = {pass_name, " read miss"};
        wr0 = wr_bursts;
        rd0 = rd_bursts;
        cpu_access(base + 32'h24, 1'b0, '0, '0, data, waits);
        check_equal("miss read data", pattern_word(base + 32'h24), data);
        expect_traffic(wr0, rd0 + 1);
        check_equal("refill address", base, ar_addr_q);
        cpu_access(base + 32'h1FC, 1'b0, '0, '0, data, waits);
        check_equal("hit read data", pattern_word(base + 32'h1FC), data);
        check_equal("hit stall cycles", 32'h0, waits);
        expect_traffic(wr0, rd0 + 1);
    endtask

    // Partial write hit, read back without stall or bus traffic
    task automatic test_write_hit(input addr_t base);
        word_t data;
        int    waits;
        int    wr0;
        int    rd0;
        test_name = {pass_name, " write hit"};
        wr0 = wr_bursts;
        rd0 = rd_bursts;
        merged_word = merge_bytes(pattern_word(base + 32'h40), 32'hDEAD_BEEF, 4'b0101);
        cpu_access(base + 32'h40, 1'b1, 32'hDEAD_BEEF, 4'b0101, data, waits);
        check_equal("write stall cycles", 32'h0, waits);
        cpu_access(base + 32'h40, 1'b0, '0, '0, data, waits);
        check_equal("merged read data", merged_word, data);
        check_equal("read stall cycles", 32'h0, waits);
        expect_traffic(wr0, rd0);
    endtask

    // Dirty block evicted by a read of another block
    task automatic test_evict(input addr_t base);
        word_t data;
        int    waits;
        int    wr0;
        int    rd0;
        test_name = {pass_name, " eviction"};
        wr0 = wr_bursts;
        rd0 = rd_bursts;
        cpu_access(base + 32'h1010, 1'b0, '0, '0, data, waits);
        check_equal("new block read data", pattern_word(base + 32'h1010), data);
        expect_traffic(wr0 + 1, rd0 + 1);
        check_equal("writeback address", base, aw_addr_q);
        check_equal("writeback beats", BURST_LEN, wr_beat);
        check_equal("written back word", merged_word, model_word(base + 32'h40));
        check_equal("refill address", base + 32'h1000, ar_addr_q);
    endtask

    // Flush writes back and stays put, the next miss finds a clean line
    task automatic test_flush(input addr_t base);
        word_t data;
        int    waits;
        int    wr0;
        int    rd0;
        test_name = {pass_name, " flush"};
        wr0 = wr_bursts;
        rd0 = rd_bursts;
        cpu_access(base + 32'h1080, 1'b1, 32'h1234_5678, 4'b1111, data, waits);
        check_equal("write stall cycles", 32'h0, waits);
        flush_line();
        expect_traffic(wr0 + 1, rd0);
        check_equal("flush address", base + 32'h1000, aw_addr_q);
        check_equal("flushed word", 32'h1234_5678, model_word(base + 32'h1080));
        cpu_access(base + 32'h2008, 1'b0, '0, '0, data, waits);
        check_equal("read after flush", pattern_word(base + 32'h2008), data);
        expect_traffic(wr0 + 1, rd0 + 1);
    endtask

    task automatic run_pass(input addr_t base, input string name);
        pass_name = name;
        test_read_miss(base);
        test_write_hit(base);
        test_evict(base);
        test_flush(base);
    endtask

    initial begin
        rst_n   = 1'b0;
        flush   = 1'b0;
        cpu_req = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_after_reset();
        run_pass(32'h0001_0000, "ready");
        // Same sequence in fresh blocks with a throttled memory
        bp_en = 1'b1;
        run_pass(32'h0004_0000, "back-pressure");
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/cache_pkg.sv
hw/axi_burst_pkg.sv
hw/block_store.sv
hw/line_tag.sv
hw/refill_ctrl.sv
hw/dm_cache.sv
tb/dm_cache_properties.sv
tb/dm_cache_tb.sv

//--- Makefile
# Verilator build and run of the single-block cache testbench

VERILATOR ?= verilator
TOP       := dm_cache_tb
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
